// File: source/usb_bus_pkg.sv
`default_nettype none

package usb_bus_pkg;

    typedef struct packed {
        logic dp;
        logic dm;
    } bus_sample_t;

    typedef struct packed {
        logic edge_start;
        logic eop;
        logic shift_enable;
        logic bit_value;
    } line_event_t;

    // full-speed line states
    localparam bus_sample_t BUS_J = '{dp: 1'b1, dm: 1'b0};
    localparam bus_sample_t BUS_K = '{dp: 1'b0, dm: 1'b1};

endpackage

`default_nettype wire

// File: source/usb_rx_pkg.sv
`default_nettype none

package usb_rx_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [3:0] pid_nibble_t;
    typedef logic [6:0] addr_t;
    typedef logic [3:0] endp_t;

    typedef enum logic [2:0] {
        PKT_NONE  = 3'd0,
        PKT_IN    = 3'd1,
        PKT_OUT   = 3'd2,
        PKT_DATA  = 3'd3,
        PKT_ACK   = 3'd4,
        PKT_NAK   = 3'd5,
        PKT_ERROR = 3'd6
    } packet_t;

    localparam byte_t SYNC_BYTE = 8'h01;

    // low nibble of the pid byte
    localparam pid_nibble_t PID_OUT   = 4'h1;
    localparam pid_nibble_t PID_IN    = 4'h9;
    localparam pid_nibble_t PID_DATA0 = 4'h3;
    localparam pid_nibble_t PID_DATA1 = 4'hB;
    localparam pid_nibble_t PID_ACK   = 4'h2;
    localparam pid_nibble_t PID_NAK   = 4'hA;

endpackage

`default_nettype wire

// File: source/usb_line_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module usb_line_decoder #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                     clk,
    input  logic                     n_rst,
    input  usb_bus_pkg::bus_sample_t bus,
    input  logic                     timer_clear,
    output usb_bus_pkg::line_event_t line_evt
);
    import usb_bus_pkg::*;

    localparam int CW = $clog2(CLKS_PER_BIT + 1);
    localparam int HALF = CLKS_PER_BIT / 2;

    bus_sample_t sync_1;
    bus_sample_t sync_2;
    bus_sample_t line_prev;
    logic [CW-1:0] bit_cnt;
    logic [2:0] ones_cnt;
    logic active;
    logic prev_dp;
    logic transition;
    logic start_k;
    logic mid_bit;
    logic se0;
    logic nrzi_bit;

    assign transition = (sync_2 != line_prev);
    assign start_k = !active && transition && (sync_2 == BUS_K);
    assign mid_bit = active && (bit_cnt == CW'(HALF));
    assign se0 = !sync_2.dp && !sync_2.dm;
    // no change on the line decodes as a one
    assign nrzi_bit = (sync_2.dp == prev_dp);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            sync_1 <= BUS_J;
            sync_2 <= BUS_J;
            line_prev <= BUS_J;
        end else begin
            sync_1 <= bus;
            sync_2 <= sync_1;
            line_prev <= sync_2;
        end
    end

    // realign on every edge of the line
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            bit_cnt <= '0;
        end else if (transition) begin
            bit_cnt <= CW'(1);
        end else if (timer_clear || bit_cnt == CW'(CLKS_PER_BIT - 1)) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            line_evt <= '0;
            active <= 1'b0;
            prev_dp <= 1'b1;
            ones_cnt <= '0;
        end else begin
            line_evt <= '0;
            if (start_k) begin
                line_evt.edge_start <= 1'b1;
                active <= 1'b1;
            end else if (mid_bit) begin
                if (se0) begin
                    line_evt.eop <= 1'b1;
                    active <= 1'b0;
                    prev_dp <= 1'b1;
                    ones_cnt <= '0;
                end else begin
                    prev_dp <= sync_2.dp;
                    if (ones_cnt == 3'd6) begin
                        // stuffed zero, dropped
                        ones_cnt <= '0;
                    end else begin
                        line_evt.shift_enable <= 1'b1;
                        line_evt.bit_value <= nrzi_bit;
                        ones_cnt <= nrzi_bit ? ones_cnt + 3'd1 : 3'd0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/usb_byte_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module usb_byte_assembler (
    input  logic                     clk,
    input  logic                     n_rst,
    input  usb_bus_pkg::line_event_t line_evt,
    output usb_rx_pkg::byte_t        rcv_data,
    output logic                     one_byte
);

    logic [2:0] bit_cnt;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            bit_cnt <= '0;
            one_byte <= 1'b0;
        end else begin
            // eighth bit in, strobe next cycle
            one_byte <= line_evt.shift_enable && (bit_cnt == 3'd7);
            if (line_evt.edge_start || line_evt.eop) begin
                bit_cnt <= '0;
            end else if (line_evt.shift_enable) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
        end
    end

    // first bit on the wire ends up as the msb
    always_ff @(posedge clk) begin
        if (line_evt.shift_enable) begin
            rcv_data <= {rcv_data[6:0], line_evt.bit_value};
        end
    end

endmodule

`default_nettype wire

// File: source/usb_rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module usb_rx_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              wr_en,
    input  usb_rx_pkg::byte_t wr_data,
    input  logic              rd_en,
    output usb_rx_pkg::byte_t rd_data,
    output logic              empty,
    output logic              full
);
    import usb_rx_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    byte_t mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic do_write;
    logic do_read;

    // extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign do_write = wr_en && !full;
    assign do_read = rd_en && !empty;
    assign rd_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/usb_rcu.sv
`timescale 1ns/1ps
`default_nettype none

module usb_rcu #(
    parameter usb_rx_pkg::addr_t DEV_ADDR = 7'h00,
    parameter usb_rx_pkg::endp_t DEV_ENDP = 4'h0
) (
    input  logic                     clk,
    input  logic                     n_rst,
    input  usb_bus_pkg::line_event_t line_evt,
    input  logic                     one_byte,
    input  usb_rx_pkg::byte_t        rcv_data,
    output usb_rx_pkg::packet_t      rx_packet,
    output logic                     store_rx_packet,
    output logic                     receiving,
    output logic                     w_enable_buffer,
    output logic                     r_error,
    output logic                     timer_clear,
    output logic                     packet_done
);
    import usb_rx_pkg::*;

    typedef enum logic [3:0] {
        idle,
        load_sync,
        load_pid,
        data_state,
        token,
        token_number,
        error_state,
        wait_eop,
        transfer_done
    } state_t;

    state_t state;
    state_t next_state;
    packet_t next_rx_packet;
    logic endp_lsb;
    logic next_endp_lsb;
    logic aligned;
    logic first_pending;
    pid_nibble_t pid;
    endp_t endp_rx;

    assign pid = rcv_data[3:0];
    // endpoint straddles the two token bytes
    assign endp_rx = {rcv_data[2:0], endp_lsb};

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= idle;
            rx_packet <= PKT_NONE;
            endp_lsb <= 1'b0;
            aligned <= 1'b0;
            first_pending <= 1'b0;
            w_enable_buffer <= 1'b0;
            store_rx_packet <= 1'b0;
        end else begin
            state <= next_state;
            rx_packet <= next_rx_packet;
            endp_lsb <= next_endp_lsb;
            if (one_byte) begin
                aligned <= 1'b1;
            end else if (line_evt.shift_enable) begin
                aligned <= 1'b0;
            end
            if (state == load_pid && next_state == data_state) begin
                first_pending <= 1'b1;
            end else if (w_enable_buffer) begin
                first_pending <= 1'b0;
            end
            w_enable_buffer <= (state == data_state) && one_byte && !line_evt.eop;
            store_rx_packet <= w_enable_buffer && first_pending;
        end
    end

    always_comb begin
        next_state = state;
        next_rx_packet = rx_packet;
        next_endp_lsb = endp_lsb;
        case (state)
            idle, error_state, transfer_done: begin
                if (line_evt.edge_start) begin
                    next_state = load_sync;
                    next_rx_packet = PKT_NONE;
                end
            end
            load_sync: begin
                if (line_evt.eop) begin
                    next_state = error_state;
                end else if (one_byte) begin
                    next_state = (rcv_data == SYNC_BYTE) ? load_pid : error_state;
                end
            end
            load_pid: begin
                if (line_evt.eop) begin
                    next_state = error_state;
                end else if (one_byte) begin
                    case (pid)
                        PID_OUT: begin
                            next_state = token;
                            next_rx_packet = PKT_OUT;
                        end
                        PID_IN: begin
                            next_state = token;
                            next_rx_packet = PKT_IN;
                        end
                        PID_DATA0, PID_DATA1: begin
                            next_state = data_state;
                            next_rx_packet = PKT_DATA;
                        end
                        PID_ACK: begin
                            next_state = wait_eop;
                            next_rx_packet = PKT_ACK;
                        end
                        PID_NAK: begin
                            next_state = wait_eop;
                            next_rx_packet = PKT_NAK;
                        end
                        default: begin
                            next_state = error_state;
                            next_rx_packet = PKT_ERROR;
                        end
                    endcase
                end
            end
            token: begin
                if (line_evt.eop) begin
                    next_state = error_state;
                end else if (one_byte) begin
                    if (rcv_data[6:0] != DEV_ADDR) begin
                        next_state = wait_eop;
                        next_rx_packet = PKT_NONE;
                    end else begin
                        next_state = token_number;
                        next_endp_lsb = rcv_data[7];
                    end
                end
            end
            token_number: begin
                if (line_evt.eop) begin
                    next_state = error_state;
                end else if (one_byte) begin
                    next_state = wait_eop;
                    if (endp_rx != DEV_ENDP) begin
                        next_rx_packet = PKT_NONE;
                    end
                end
            end
            data_state: begin
                // eop must land on a byte boundary
                if (line_evt.eop) begin
                    next_state = (aligned || one_byte) ? transfer_done : error_state;
                end
            end
            wait_eop: begin
                if (line_evt.eop) begin
                    next_state = transfer_done;
                end
            end
            default: next_state = idle;
        endcase
    end

    always_comb begin
        receiving = 1'b0;
        r_error = 1'b0;
        packet_done = 1'b0;
        timer_clear = 1'b0;
        case (state)
            load_sync, load_pid, data_state, token, token_number, wait_eop: begin
                receiving = 1'b1;
            end
            error_state: r_error = 1'b1;
            transfer_done: begin
                packet_done = 1'b1;
                timer_clear = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/usb_rx.sv
`timescale 1ns/1ps
`default_nettype none

module usb_rx #(
    parameter int                CLKS_PER_BIT = 8,
    parameter usb_rx_pkg::addr_t DEV_ADDR     = 7'h00,
    parameter usb_rx_pkg::endp_t DEV_ENDP     = 4'h0,
    parameter int                FIFO_DEPTH   = 16
) (
    input  logic                     clk,
    input  logic                     n_rst,
    input  usb_bus_pkg::bus_sample_t bus,
    input  logic                     rd_en,
    output usb_rx_pkg::byte_t        rd_data,
    output logic                     fifo_empty,
    output logic                     fifo_full,
    output usb_rx_pkg::packet_t      rx_packet,
    output logic                     receiving,
    output logic                     packet_done,
    output logic                     r_error,
    output logic                     data_start
);
    import usb_bus_pkg::*;
    import usb_rx_pkg::*;

    line_event_t line_evt;
    byte_t rcv_data;
    logic one_byte;
    logic timer_clear;
    logic w_enable_buffer;

    usb_line_decoder #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_decoder (
        .clk        (clk),
        .n_rst      (n_rst),
        .bus        (bus),
        .timer_clear(timer_clear),
        .line_evt   (line_evt)
    );

    usb_byte_assembler i_assembler (
        .clk     (clk),
        .n_rst   (n_rst),
        .line_evt(line_evt),
        .rcv_data(rcv_data),
        .one_byte(one_byte)
    );

    usb_rcu #(
        .DEV_ADDR(DEV_ADDR),
        .DEV_ENDP(DEV_ENDP)
    ) i_rcu (
        .clk            (clk),
        .n_rst          (n_rst),
        .line_evt       (line_evt),
        .one_byte       (one_byte),
        .rcv_data       (rcv_data),
        .rx_packet      (rx_packet),
        .store_rx_packet(data_start),
        .receiving      (receiving),
        .w_enable_buffer(w_enable_buffer),
        .r_error        (r_error),
        .timer_clear    (timer_clear),
        .packet_done    (packet_done)
    );

    usb_rx_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_fifo (
        .clk    (clk),
        .n_rst  (n_rst),
        .wr_en  (w_enable_buffer),
        .wr_data(rcv_data),
        .rd_en  (rd_en),
        .rd_data(rd_data),
        .empty  (fifo_empty),
        .full   (fifo_full)
    );

endmodule

`default_nettype wire

// File: dv/usb_rx_sva.sv
`timescale 1ns/1ps
`default_nettype none

module usb_rx_sva (
    input logic clk,
    input logic n_rst,
    input logic receiving,
    input logic w_enable_buffer,
    input logic r_error,
    input logic packet_done,
    input logic store_rx_packet
);

    // done and error come from different states
    a_done_or_error: assert property (@(posedge clk) disable iff (!n_rst)
        !(packet_done && r_error))
        else $error("packet_done and r_error high together");

    a_write_in_packet: assert property (@(posedge clk) disable iff (!n_rst)
        w_enable_buffer |-> receiving)
        else $error("buffer write outside a packet");

    a_start_pulse: assert property (@(posedge clk) disable iff (!n_rst)
        store_rx_packet |=> !store_rx_packet)
        else $error("store_rx_packet longer than one cycle");

endmodule

bind usb_rcu usb_rx_sva i_sva (
    .clk            (clk),
    .n_rst          (n_rst),
    .receiving      (receiving),
    .w_enable_buffer(w_enable_buffer),
    .r_error        (r_error),
    .packet_done    (packet_done),
    .store_rx_packet(store_rx_packet)
);

`default_nettype wire

// File: dv/usb_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module usb_rx_tb;
    import usb_bus_pkg::*;
    import usb_rx_pkg::*;

    localparam int CLKS_PER_BIT = 8;
    localparam int FIFO_DEPTH = 16;
    localparam int DRIVE_DLY = 2;
    localparam int IDLE_BITS = 2;
    localparam int NUM_ROWS = 12;
    localparam bus_sample_t BUS_SE0 = '{dp: 1'b0, dm: 1'b0};

    typedef struct packed {
        byte_t      pid;
        byte_t      sync;
        logic [4:0] len;
        logic       cut;
        addr_t      addr;
        endp_t      endp;
        packet_t    exp_pkt;
        logic       exp_err;
    } row_t;

    // pid, sync, body length, cut eop, token addr, token endp, packet, error
    row_t rows [NUM_ROWS] = '{
        '{8'hE1, 8'h01, 5'd2, 1'b0, 7'h70, 4'h4, PKT_OUT, 1'b0},
        '{8'h69, 8'h01, 5'd2, 1'b0, 7'h70, 4'h4, PKT_IN, 1'b0},
        '{8'hE1, 8'h01, 5'd2, 1'b0, 7'h71, 4'h4, PKT_NONE, 1'b0},
        '{8'h69, 8'h01, 5'd2, 1'b0, 7'h70, 4'h5, PKT_NONE, 1'b0},
        '{8'hD2, 8'h01, 5'd0, 1'b0, 7'h00, 4'h0, PKT_ACK, 1'b0},
        '{8'h5A, 8'h01, 5'd0, 1'b0, 7'h00, 4'h0, PKT_NAK, 1'b0},
        '{8'hC3, 8'h01, 5'd4, 1'b0, 7'h00, 4'h0, PKT_DATA, 1'b0},
        '{8'h4B, 8'h01, 5'd12, 1'b0, 7'h00, 4'h0, PKT_DATA, 1'b0},
        '{8'hD2, 8'h05, 5'd0, 1'b0, 7'h00, 4'h0, PKT_NONE, 1'b1},
        '{8'h87, 8'h01, 5'd0, 1'b0, 7'h00, 4'h0, PKT_ERROR, 1'b1},
        '{8'hC3, 8'h01, 5'd3, 1'b1, 7'h00, 4'h0, PKT_DATA, 1'b1},
        '{8'h4B, 8'h01, 5'd16, 1'b0, 7'h00, 4'h0, PKT_DATA, 1'b0}
    };

    logic clk;
    logic n_rst;
    bus_sample_t bus;
    logic rd_en;
    byte_t rd_data;
    logic fifo_empty;
    logic fifo_full;
    packet_t rx_packet;
    logic receiving;
    logic packet_done;
    logic r_error;
    logic data_start;

    bus_sample_t line_lvl;
    int ones_run;
    logic [31:0] lcg_state = 32'd4;
    byte_t exp_q [$];
    int start_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    usb_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .DEV_ADDR    (7'h70),
        .DEV_ENDP    (4'h4),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: no result after %0d clock cycles", cycle_limit);
            $display("FAIL: see errors above");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    always @(posedge clk) begin
        if (data_start) begin
            start_count = start_count + 1;
        end
    end

    function automatic byte_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic logic is_token(input byte_t pid);
        return pid[3:0] == PID_OUT || pid[3:0] == PID_IN;
    endfunction

    function automatic logic is_data(input byte_t pid);
        return pid[3:0] == PID_DATA0 || pid[3:0] == PID_DATA1;
    endfunction

    function automatic byte_t body_byte(input row_t r, input int idx);
        byte_t rnd;
        rnd = next_rand();
        if (is_token(r.pid)) begin
            // address and endpoint lsb, then endpoint msbs under random crc5 bits
            return (idx == 0) ? {r.endp[0], r.addr} : {rnd[4:0], r.endp[3:1]};
        end
        // every third byte all ones, forces stuffing
        return (idx % 3 == 1) ? 8'hFF : rnd;
    endfunction

    function automatic int cycle_budget();
        int bits;
        int total;
        total = 10 + 200;
        foreach (rows[i]) begin
            bits = IDLE_BITS + 16 + 8 * int'(rows[i].len) + 3 * int'(rows[i].cut) + 3;
            total += (bits + bits / 6 + 2) * CLKS_PER_BIT + int'(rows[i].len) + 8;
        end
        return total;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "check failed");
        end
    endtask

    task automatic drive_line(input bus_sample_t lvl);
        bus = lvl;
        repeat (CLKS_PER_BIT) @(posedge clk);
        #DRIVE_DLY;
    endtask

    // nrzi: a zero toggles the line, a one holds it
    task automatic send_bit(input logic b);
        if (!b) begin
            line_lvl = (line_lvl == BUS_J) ? BUS_K : BUS_J;
        end
        drive_line(line_lvl);
        ones_run = b ? ones_run + 1 : 0;
        if (ones_run == 6) begin
            line_lvl = (line_lvl == BUS_J) ? BUS_K : BUS_J;
            drive_line(line_lvl);
            ones_run = 0;
        end
    endtask

    task automatic send_byte(input byte_t value);
        int i;
        for (i = 7; i >= 0; i--) begin
            send_bit(value[i]);
        end
    endtask

    task automatic send_eop();
        drive_line(BUS_SE0);
        drive_line(BUS_SE0);
        line_lvl = BUS_J;
        drive_line(line_lvl);
        ones_run = 0;
    endtask

    task automatic drain_fifo(input string tag);
        byte_t exp_b;
        check_value(32'(fifo_full), 32'(exp_q.size() >= FIFO_DEPTH), {tag, " fifo_full"});
        while (exp_q.size() > 0) begin
            exp_b = exp_q.pop_front();
            check_value(32'(fifo_empty), 32'd0, {tag, " fifo_empty during drain"});
            check_value(32'(rd_data), 32'(exp_b), {tag, " rd_data"});
            rd_en = 1'b1;
            @(posedge clk);
            #DRIVE_DLY;
            rd_en = 1'b0;
        end
        check_value(32'(fifo_empty), 32'd1, {tag, " fifo_empty after drain"});
    endtask

    task automatic run_row(input row_t r, input int idx);
        string tag;
        byte_t b;
        logic keep;
        int k;
        int starts_before;
        tag = $sformatf("row %0d", idx);
        keep = is_data(r.pid) && (r.sync == SYNC_BYTE);
        starts_before = start_count;
        line_lvl = BUS_J;
        ones_run = 0;
        repeat (IDLE_BITS) begin
            drive_line(BUS_J);
        end
        send_byte(r.sync);
        send_byte(r.pid);
        for (k = 0; k < int'(r.len); k++) begin
            b = body_byte(r, k);
            if (keep) begin
                exp_q.push_back(b);
            end
            send_byte(b);
        end
        // eop three bits into a byte
        if (r.cut) begin
            send_bit(1'b1);
            send_bit(1'b0);
            send_bit(1'b1);
        end
        send_eop();
        while (!(packet_done || r_error)) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        check_value(32'(rx_packet), 32'(r.exp_pkt), {tag, " rx_packet"});
        check_value(32'(r_error), 32'(r.exp_err), {tag, " r_error"});
        check_value(32'(packet_done), 32'(!r.exp_err), {tag, " packet_done"});
        check_value(32'(receiving), 32'd0, {tag, " receiving"});
        check_value(32'(start_count - starts_before), 32'(keep && r.len != 0),
                    {tag, " data_start pulses"});
        drain_fifo(tag);
    endtask

    initial begin
        n_rst = 1'b0;
        bus = BUS_J;
        rd_en = 1'b0;
        line_lvl = BUS_J;
        ones_run = 0;
        cycle_limit = cycle_budget();
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        n_rst = 1'b1;
        check_value(32'(rx_packet), 32'(PKT_NONE), "reset rx_packet");
        check_value(32'(receiving), 32'd0, "reset receiving");
        check_value(32'(packet_done), 32'd0, "reset packet_done");
        check_value(32'(r_error), 32'd0, "reset r_error");
        check_value(32'(data_start), 32'd0, "reset data_start");
        check_value(32'(fifo_empty), 32'd1, "reset fifo_empty");
        check_value(32'(fifo_full), 32'd0, "reset fifo_full");
        foreach (rows[i]) begin
            run_row(rows[i], i);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: usb_rx.f
source/usb_bus_pkg.sv
source/usb_rx_pkg.sv
source/usb_line_decoder.sv
source/usb_byte_assembler.sv
source/usb_rx_fifo.sv
source/usb_rcu.sv
source/usb_rx.sv
dv/usb_rx_sva.sv
dv/usb_rx_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= usb_rx_tb
FILELIST  ?= usb_rx.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
